// File: sim.f
design/fir_pkg.sv
design/fir_cfg_if.sv
design/fir_result_if.sv
design/fir_reg_decode.sv
design/fir_mac_engine.sv
design/fir_stream_out.sv
design/fir_top.sv
sim/fir_tb.sv

// File: sim/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;
    import fir_pkg::*;

    localparam int num_rows = 4;
    localparam int timeout  = 400;   // cycles per wait

    typedef struct packed {
        logic [num_taps-1:0][data_w-1:0] taps;   // tap 0 rightmost
        sample_t                         len;
        logic                            rnd;    // random sm_tready
    } case_t;

    logic    clk;
    logic    rst_n;
    logic    awvalid, awready, wvalid, wready;
    addr_t   awaddr, araddr;
    sample_t wdata, rdata;
    logic    arvalid, arready, rvalid, rready;
    logic    ss_tvalid, ss_tready;
    sample_t ss_tdata;
    logic    sm_tvalid, sm_tready, sm_tlast;
    sample_t sm_tdata;

    case_t  rows [num_rows];
    integer seed = 32'h78a3;
    int     mism_cnt = 0;
    int     fail_cnt = 0;

    fir_top u_dut (.*);

    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("timeout waiting for %s", what);
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt + 1);
        $display("TESTS FAILED");
        $finish;
    endtask

    // sum of tap i times sample n-i, nothing before the block start
    function automatic sample_t model_out(input int row, input int n);
        sample_t acc;
        sample_t x;
        acc = '0;
        for (int i = 0; i < num_taps; i++) begin
            if (n - i >= 0) begin
                x   = sample_t'(row * 16 + (n - i) + 1);
                acc = acc + rows[row].taps[i] * x;
            end
        end
        return acc;
    endfunction

    task automatic write_reg(input addr_t addr, input sample_t data);
        logic aw_ok;
        logic w_ok;
        int   t;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        t     = 0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(aw_ok && w_ok)) begin
            #1;
            if (awvalid && awready) aw_ok = 1'b1;
            if (wvalid && wready) w_ok = 1'b1;
            @(negedge clk);
            if (aw_ok) awvalid = 1'b0;   // accepted on the edge just passed
            if (w_ok) wvalid = 1'b0;
            t++;
            if (t > timeout) abort_run("register write");
        end
        @(negedge clk);   // register commits here
    endtask

    task automatic read_reg(input addr_t addr, output sample_t data);
        int t;
        t = 0;
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > timeout) abort_run("read address");
        end
        @(negedge clk);
        arvalid = 1'b0;
        #1;
        while (!rvalid) begin
            @(negedge clk);
            #1;
            t++;
            if (t > timeout) abort_run("read data");
        end
        data = rdata;
        @(negedge clk);   // rready is always high, rvalid drops here
    endtask

    task automatic check_reg(input addr_t addr, input sample_t exp, input string name);
        sample_t got;
        read_reg(addr, got);
        if (got !== exp) begin
            $display("mismatch rdata (%s): got %h expected %h", name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic send_samples(input int row);
        int t;
        for (int n = 0; n < int'(rows[row].len); n++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = sample_t'(row * 16 + n + 1);
            t = 0;
            #1;
            while (!ss_tready) begin
                @(negedge clk);
                #1;
                t++;
                if (t > timeout) abort_run("ss_tready");
            end
            @(negedge clk);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int row);
        int      t;
        logic    got;
        sample_t data;
        logic    last;
        for (int k = 0; k < int'(rows[row].len); k++) begin
            t   = 0;
            got = 1'b0;
            while (!got) begin
                sm_tready = rows[row].rnd ? ($random(seed) & 1) : 1'b1;
                #1;
                if (sm_tvalid && sm_tready) begin
                    got  = 1'b1;
                    data = sm_tdata;
                    last = sm_tlast;
                end
                @(negedge clk);
                t++;
                if (!got && t > timeout) abort_run("sm_tvalid");
            end
            if (data !== model_out(row, k)) begin
                $display("mismatch sm_tdata row %0d out %0d: got %h expected %h",
                         row, k, data, model_out(row, k));
                mism_cnt++;
            end
            if (last !== (k == int'(rows[row].len) - 1)) begin
                $display("mismatch sm_tlast row %0d out %0d: got %h expected %h",
                         row, k, last, (k == int'(rows[row].len) - 1));
                mism_cnt++;
            end
        end
        sm_tready = 1'b0;
    endtask

    initial begin
        rows[0].taps = {32'd11, 32'd10, 32'd9, 32'd8, 32'd7, 32'd6, 32'd5, 32'd4, 32'd3,
                        32'd2, 32'd1};
        rows[0].len  = 32'd14;
        rows[0].rnd  = 1'b0;
        // large taps so products and sums wrap
        rows[1].taps = {32'h8000_0001, 32'hffff_ffff, 32'h0000_0003, 32'h7fff_fff0,
                        32'hffff_fffe, 32'h0000_0100, 32'h1234_5678, 32'h0000_0000,
                        32'hdead_beef, 32'h0000_0005, 32'hfffe_0001};
        rows[1].len  = 32'd25;
        rows[1].rnd  = 1'b1;
        rows[2].taps = {32'd2, {9{32'd0}}, 32'hffff_ffff};   // block shorter than taps
        rows[2].len  = 32'd3;
        rows[2].rnd  = 1'b1;
        rows[3].taps = {32'd1, 32'd2, 32'd3, 32'd4, 32'd5, 32'd6, 32'd7, 32'd8, 32'd9,
                        32'd10, 32'd11};
        rows[3].len  = 32'd11;
        rows[3].rnd  = 1'b0;

        clk       = 1'b0;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b1;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_reg(reg_ctrl, 32'h4, "ctrl after reset");
        if (sm_tvalid !== 1'b0) begin
            $display("mismatch sm_tvalid after reset: got %h expected %h", sm_tvalid, 1'b0);
            mism_cnt++;
        end

        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < num_taps; i++)
                write_reg(reg_tap_base + addr_t'(4 * i), rows[r].taps[i]);
            write_reg(reg_len, rows[r].len);
            for (int i = 0; i < num_taps; i++)
                check_reg(reg_tap_base + addr_t'(4 * i), rows[r].taps[i], "tap readback");
            check_reg(reg_len, rows[r].len, "len readback");

            write_reg(reg_ctrl, 32'h1);
            fork
                send_samples(r);
                collect_outputs(r);
            join
            #1;
            if (sm_tvalid !== 1'b0) begin
                $display("extra output after the last one of row %0d", r);
                fail_cnt++;
            end
            check_reg(reg_ctrl, 32'h2, "ctrl done");   // done set, idle still clear
            check_reg(reg_ctrl, 32'h4, "ctrl idle");
        end

        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: design/fir_top.sv
`timescale 1ns/1ps

module fir_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    output logic             wready,
    input  fir_pkg::sample_t wdata,
    input  logic             arvalid,
    output logic             arready,
    input  fir_pkg::addr_t   araddr,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    input  logic             ss_tvalid,
    output logic             ss_tready,
    input  fir_pkg::sample_t ss_tdata,
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output fir_pkg::sample_t sm_tdata,
    output logic             sm_tlast
);

    fir_cfg_if    cfg_bus ();   // decode to engine and output stage
    fir_result_if res_bus ();   // engine to output stage

    fir_reg_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .block_done (res_bus.block_done),
        .cfg        (cfg_bus.decode)
    );

    fir_mac_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .ss_tvalid (ss_tvalid),
        .ss_tready (ss_tready),
        .ss_tdata  (ss_tdata),
        .cfg       (cfg_bus.engine),
        .res       (res_bus.engine)
    );

    fir_stream_out u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .sm_tvalid (sm_tvalid),
        .sm_tready (sm_tready),
        .sm_tdata  (sm_tdata),
        .sm_tlast  (sm_tlast),
        .res       (res_bus.out),
        .cfg       (cfg_bus.mon)
    );

endmodule

// File: design/fir_stream_out.sv
`timescale 1ns/1ps

module fir_stream_out (
    input  logic             clk,
    input  logic             rst_n,
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output fir_pkg::sample_t sm_tdata,
    output logic             sm_tlast,
    fir_result_if.out        res,
    fir_cfg_if.mon           cfg
);
    import fir_pkg::*;

    sample_t remain;   // outputs left in this block
    logic    sm_fire;
    logic    res_fire;

    assign sm_fire  = sm_tvalid && sm_tready;
    assign res_fire = res.res_valid && res.res_ready;

    // take a new result when empty or draining this cycle
    assign res.res_ready  = !sm_tvalid || sm_tready;
    assign sm_tlast       = sm_tvalid && (remain == sample_t'(1));
    assign res.block_done = sm_fire && sm_tlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sm_tvalid <= 1'b0;
            remain    <= '0;
        end else begin
            if (res_fire)
                sm_tvalid <= 1'b1;
            else if (sm_fire)
                sm_tvalid <= 1'b0;
            if (cfg.start)
                remain <= cfg.length;
            else if (sm_fire)
                remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (res_fire)
            sm_tdata <= res.res_data;
    end

    a_hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast));

endmodule

// File: design/fir_mac_engine.sv
`timescale 1ns/1ps

module fir_mac_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ss_tvalid,
    output logic             ss_tready,
    input  fir_pkg::sample_t ss_tdata,
    fir_cfg_if.engine        cfg,
    fir_result_if.engine     res
);
    import fir_pkg::*;

    eng_state_t state;
    ptr_t       cnt;
    ptr_t       wr_ptr;   // slot for the next sample
    ptr_t       rd_ptr;   // walks back from newest during calc
    sample_t    hist [num_taps];
    sample_t    acc;
    sample_t    prod;
    sample_t    sum;
    logic       last_tap;
    logic       ss_fire;

    assign ss_tready = (state == load);
    assign ss_fire   = ss_tvalid && ss_tready;
    assign last_tap  = (cnt == ptr_t'(num_taps - 1));
    assign cfg.busy  = (state != idle);

    // products and sums wrap at 32 bits
    assign prod = cfg.taps[cnt] * hist[rd_ptr];
    assign sum  = acc + prod;

    // result goes out straight from the adder on the last tap
    assign res.res_valid = ((state == calc) && last_tap) || (state == hold);
    assign res.res_data  = (state == hold) ? acc : sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            cnt    <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cfg.start) begin
                        state  <= zero_fill;
                        cnt    <= '0;
                        wr_ptr <= '0;
                    end
                end
                zero_fill: begin
                    if (last_tap) begin
                        state <= load;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                load: begin
                    if (res.block_done) begin
                        state <= idle;
                    end else if (ss_fire) begin
                        state  <= calc;
                        cnt    <= '0;
                        rd_ptr <= wr_ptr;
                        wr_ptr <= (wr_ptr == ptr_t'(num_taps - 1)) ? '0 : wr_ptr + 1'b1;
                    end
                end
                calc: begin
                    if (last_tap) begin
                        state <= res.res_ready ? load : hold;
                        cnt   <= '0;
                    end else begin
                        cnt    <= cnt + 1'b1;
                        rd_ptr <= (rd_ptr == '0) ? ptr_t'(num_taps - 1) : rd_ptr - 1'b1;
                    end
                end
                hold: begin
                    if (res.res_ready)
                        state <= load;   // output register freed up
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == zero_fill)
            hist[cnt] <= '0;
        if (ss_fire) begin
            hist[wr_ptr] <= ss_tdata;
            acc          <= '0;
        end else if (state == calc) begin
            acc <= sum;   // final sum parks here for hold
        end
    end

    // input stays closed while the taps are walked
    a_tready_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        ss_fire |=> !ss_tready [*num_taps]);

endmodule

// File: design/fir_reg_decode.sv
`timescale 1ns/1ps

module fir_reg_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    output logic             wready,
    input  fir_pkg::sample_t wdata,
    input  logic             arvalid,
    output logic             arready,
    input  fir_pkg::addr_t   araddr,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    input  logic             block_done,
    fir_cfg_if.decode        cfg
);
    import fir_pkg::*;

    addr_t   aw_addr;
    sample_t w_data;
    logic    aw_got;
    logic    w_got;
    logic    aw_fire;
    logic    w_fire;
    logic    wr_commit;
    logic    ar_fire;
    logic    ctrl_read;
    logic    ap_start;
    logic    ap_done;
    logic    ap_idle;
    sample_t length_q;
    sample_t taps_q [num_taps];
    sample_t rd_mux;

    function automatic logic tap_hit(addr_t a);
        return (a >= reg_tap_base) && (a < reg_tap_base + addr_t'(4 * num_taps));
    endfunction

    function automatic ptr_t tap_idx(addr_t a);
        addr_t off;
        off = a - reg_tap_base;
        return ptr_t'(off >> 2);
    endfunction

    // address and data may land in either order, commit once both are held
    assign awready   = !aw_got && !cfg.busy && !ap_start;
    assign wready    = !w_got && !cfg.busy && !ap_start;
    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign wr_commit = aw_got && w_got;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else if (wr_commit) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            if (aw_fire)
                aw_got <= 1'b1;
            if (w_fire)
                w_got <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire)
            aw_addr <= awaddr;
        if (w_fire)
            w_data <= wdata;
        if (wr_commit && tap_hit(aw_addr))
            taps_q[tap_idx(aw_addr)] <= w_data;
    end

    assign ar_fire   = arvalid && arready;
    assign ctrl_read = ar_fire && (araddr == reg_ctrl);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            length_q <= '0;
        end else begin
            ap_start <= wr_commit && (aw_addr == reg_ctrl) && w_data[0] && ap_idle
                        && !cfg.busy;   // single pulse
            if (wr_commit && (aw_addr == reg_len))
                length_q <= w_data;
            if (block_done)
                ap_done <= 1'b1;
            else if (ctrl_read && ap_done)
                ap_done <= 1'b0;   // cleared by status read
            if (ap_start)
                ap_idle <= 1'b0;
            else if (ctrl_read && ap_done && !block_done)
                ap_idle <= 1'b1;
        end
    end

    assign cfg.start  = ap_start;
    assign cfg.length = length_q;
    assign cfg.taps   = taps_q;

    always_comb begin
        rd_mux = '0;
        if (araddr == reg_ctrl)
            rd_mux = sample_t'({ap_idle, ap_done, ap_start});
        else if (araddr == reg_len)
            rd_mux = length_q;
        else if (tap_hit(araddr))
            rd_mux = taps_q[tap_idx(araddr)];
    end

    // one read in flight at a time
    assign arready = !rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rvalid <= 1'b0;
        else if (ar_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            rdata <= rd_mux;   // status sampled before done clears
    end

    a_rvalid_needs_ar: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(ar_fire));

endmodule

// File: design/fir_result_if.sv
`timescale 1ns/1ps

interface fir_result_if;
    import fir_pkg::*;

    logic    res_valid;
    sample_t res_data;
    logic    res_ready;
    logic    block_done;   // pulse on transfer of the last Yn

    modport engine (
        output res_valid,
        output res_data,
        input  res_ready,
        input  block_done
    );

    modport out (
        input  res_valid,
        input  res_data,
        output res_ready,
        output block_done
    );

endinterface

// File: design/fir_cfg_if.sv
`timescale 1ns/1ps

interface fir_cfg_if;
    import fir_pkg::*;

    sample_t taps [num_taps];   // coefficient set, tap 0 pairs with newest sample
    logic    start;             // one-cycle pulse from the control register
    sample_t length;            // block length in outputs
    logic    busy;              // engine not idle

    modport decode (
        output taps,
        output start,
        output length,
        input  busy
    );

    modport engine (
        input  taps,
        input  start,
        output busy
    );

    // output stage only watches start and length
    modport mon (
        input start,
        input length
    );

endinterface

// File: design/fir_pkg.sv
package fir_pkg;

    // filter geometry
    localparam int num_taps = 11;
    localparam int addr_w   = 12;
    localparam int data_w   = 32;
    localparam int ptr_w    = 4;   // enough to index num_taps entries

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] sample_t;   // samples, taps and results share one width
    typedef logic [ptr_w-1:0]  ptr_t;

    // register map
    localparam addr_t reg_ctrl     = 12'h000;   // {idle, done, start}
    localparam addr_t reg_len      = 12'h010;   // outputs per block
    localparam addr_t reg_tap_base = 12'h020;   // tap i at base + 4*i

    // MAC engine states
    typedef enum logic [2:0] {
        idle,        // waiting for start
        zero_fill,   // clearing sample history
        load,        // waiting for next Xn
        calc,        // one tap per cycle
        hold         // result waiting for output stage
    } eng_state_t;

endpackage
